//--- scannerTop.f
design/scanPkg.sv
design/frameCmdPkg.sv
design/scanControl.sv
design/frameSerializer.sv
design/scannerTop.sv
dv/frameChecker.sv
dv/scannerTb.sv

//--- runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
simOut="$(verilator --binary --timing -Wno-fatal --top-module scannerTb \
	-f scannerTop.f -Mdir obj_dir -o scannerSim 1>&2 && ./obj_dir/scannerSim)" \
	|| echo "Build or simulation step returned an error"
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx "STATUS: PASS" \
	&& echo "Result: simulation passed" \
	|| { echo "Result: simulation failed"; exit 1; }

//--- dv/scannerTb.sv
`timescale 1ns/1ps

module scannerTb;

	import frameCmdPkg::*;

	localparam int unsigned SLOW_DIV     = 16;
	localparam int unsigned CLK_PERIOD   = 4;
	localparam int unsigned DRIVE_DELAY  = 1;
	localparam int unsigned RESET_CYCLES = 10;
	localparam int unsigned NUM_ROWS     = 5;
	localparam int unsigned TICK_NS      = SLOW_DIV * CLK_PERIOD;
	// Table rows plus the reset scan and the recovery scan
	localparam int unsigned TIMEOUT_NS   = (NUM_ROWS + 2) * 20 * TICK_NS + 100 * CLK_PERIOD;

	typedef struct packed {
		logic       ready;        // readyForTransfer level for the scan
		logic       peerHalf;     // Release STANDBY with LINK_PEER_HALF
		logic [3:0] standbyTicks; // Ticks spent in STANDBY before that
		logic [7:0] idleCycles;   // Gap before the next start
	} stimRow_t;

	localparam stimRow_t STIM_TABLE [NUM_ROWS] = '{
		'{ready: 1'b1, peerHalf: 1'b0, standbyTicks: 4'd0, idleCycles: 8'd20},
		'{ready: 1'b0, peerHalf: 1'b1, standbyTicks: 4'd2, idleCycles: 8'd35},
		'{ready: 1'b1, peerHalf: 1'b0, standbyTicks: 4'd0, idleCycles: 8'd5},
		'{ready: 1'b0, peerHalf: 1'b1, standbyTicks: 4'd0, idleCycles: 8'd12},
		'{ready: 1'b0, peerHalf: 1'b1, standbyTicks: 4'd3, idleCycles: 8'd40}
	};

	logic        clk;
	logic        rst;
	linkCode_t   peerLink;
	logic        readyForTransfer;
	logic        clkOut;
	logic        dataOut;
	logic        scanBusy;
	int unsigned errCount;
	int unsigned byteCount;
	int unsigned scanCount;
	int unsigned tbErrors = 0;
	int unsigned row;

	scannerTop #(
		.SLOW_DIV(SLOW_DIV)
	) u_scannerTop (
		.clk(clk),
		.rst(rst),
		.peerLink(peerLink),
		.readyForTransfer(readyForTransfer),
		.clkOut(clkOut),
		.dataOut(dataOut),
		.scanBusy(scanBusy)
	);

	frameChecker u_frameChecker (
		.clk(clk),
		.rst(rst),
		.peerLink(peerLink),
		.readyForTransfer(readyForTransfer),
		.clkOut(clkOut),
		.dataOut(dataOut),
		.scanBusy(scanBusy),
		.errCount(errCount),
		.byteCount(byteCount),
		.scanCount(scanCount)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the scans did not finish within %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	// Each step ends just after a rising edge, where inputs change
	task automatic stepCycles(input int unsigned count);
		repeat (count) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic startScan();
		peerLink = LINK_START;
		stepCycles(SLOW_DIV); // Spans exactly one slow tick
		peerLink = 2'b00;
		if (scanBusy !== 1'b1) begin
			tbErrors++;
			$display("Error at %0d ns: scanner did not leave IDLE after the start code", $time);
		end
	endtask

	task automatic waitFrames(input int unsigned count);
		int unsigned seen;
		seen = 0;
		while (seen < count) begin
			@(negedge clk);
			if (clkOut === 1'b1) begin
				while (clkOut === 1'b1) @(negedge clk);
				seen++;
			end
		end
		stepCycles(1);
	endtask

	task automatic waitIdle();
		while (scanBusy !== 1'b0) @(negedge clk);
		stepCycles(1);
	endtask

	task automatic runRow(input stimRow_t stim);
		readyForTransfer = stim.ready;
		startScan();
		if (stim.peerHalf) begin
			waitFrames(3); // 02, 03 and 04 sent and the scanner waits in STANDBY
			stepCycles(stim.standbyTicks * SLOW_DIV);
			peerLink = LINK_PEER_HALF;
			stepCycles(SLOW_DIV);
			peerLink = 2'b00;
		end
		waitIdle();
		readyForTransfer = 1'b0;
		stepCycles(stim.idleCycles + ($urandom % 8));
	endtask

	task automatic resetMidFrame();
		readyForTransfer = 1'b1;
		startScan();
		while (clkOut !== 1'b1) @(negedge clk);
		stepCycles(3); // A few bits into the 02 frame
		rst = 1'b1;
		stepCycles(3);
		rst = 1'b0;
		stepCycles(SLOW_DIV);
		if (scanBusy !== 1'b0 || clkOut !== 1'b0) begin
			tbErrors++;
			$display("Error at %0d ns: scanner not idle after the mid-frame reset", $time);
		end
		readyForTransfer = 1'b0;
	endtask

	initial begin
		void'($urandom(48));
		rst = 1'b1;
		peerLink = 2'b00;
		readyForTransfer = 1'b0;
		stepCycles(RESET_CYCLES);
		rst = 1'b0;
		stepCycles(2 * SLOW_DIV);
		if (scanBusy !== 1'b0) begin
			tbErrors++;
			$display("Error at %0d ns: scanner left IDLE without a start code", $time);
		end
		for (row = 0; row < NUM_ROWS; row++) begin
			runRow(STIM_TABLE[row]);
		end
		resetMidFrame();
		runRow('{ready: 1'b1, peerHalf: 1'b0, standbyTicks: 4'd0, idleCycles: 8'd10});
		if (scanCount != NUM_ROWS + 1) begin
			tbErrors++;
			$display("Error: %0d complete scans seen, %0d expected", scanCount, NUM_ROWS + 1);
		end
		$display("Errors: checker %0d, testbench %0d (%0d bytes and %0d scans checked)",
			errCount, tbErrors, byteCount, scanCount);
		if (errCount == 0 && tbErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : scannerTb

//--- dv/frameChecker.sv
`timescale 1ns/1ps

module frameChecker (
	input  logic                   clk,
	input  logic                   rst,
	input  frameCmdPkg::linkCode_t peerLink,
	input  logic                   readyForTransfer,
	input  logic                   clkOut,
	input  logic                   dataOut,
	input  logic                   scanBusy,
	output int unsigned            errCount,
	output int unsigned            byteCount,
	output int unsigned            scanCount
);

	import scanPkg::*;
	import frameCmdPkg::*;

	localparam int unsigned SEQ_LEN  = 5; // Bytes per scan, data byte included
	localparam int unsigned XFER_IDX = 3; // Position of the data transfer command

	int unsigned errors = 0;
	int unsigned bytesSeen = 0;
	int unsigned scansSeen = 0;
	int unsigned seqIdx = 0;
	int unsigned runStartIdx = 0;
	int unsigned runLen = 0;
	int unsigned expLen = 0;
	int unsigned bitCount = 0;
	frameByte_t  shiftByte = '0;
	logic        rstPrev = 1'b0;
	logic        busyPrev = 1'b0;
	linkCode_t   linkPrev = 2'b00;
	logic        releaseSeen = 1'b0; // Ready or peer-half seen since the 03 byte

	assign errCount = errors;
	assign byteCount = bytesSeen;
	assign scanCount = scansSeen;

	// Byte expected at a given position of one scan
	function automatic frameByte_t expectedByte(input int unsigned idx);
		case (idx)
			0: return 8'h02; // Fill reached 80 percent
			1: return 8'h03;
			2: return 8'h04; // Buffer full
			3: return 8'h07;
			default: return frameByte_t'(FILL_FULL); // Fill level when the transfer starts
		endcase
	endfunction

	// Sampled mid-cycle, away from the edges where the DUT and the driver move
	always @(negedge clk) begin
		if (rstPrev && (clkOut !== 1'b0 || scanBusy !== 1'b0)) begin
			errors++;
			$display("Error at %0d ns: clkOut or scanBusy still high one cycle into reset", $time);
		end
		if (rst) begin
			seqIdx = 0; // Partial byte and scan are dropped
			runLen = 0;
			bitCount = 0;
			releaseSeen = 1'b0;
		end else begin
			if (scanBusy === 1'b1 && busyPrev !== 1'b1 && linkPrev !== LINK_START) begin
				errors++;
				$display("Error at %0d ns: scanBusy rose without a start code on the peer link",
					$time);
			end
			if (readyForTransfer === 1'b1 || peerLink === LINK_PEER_HALF) begin
				releaseSeen = 1'b1;
			end
			if ((seqIdx != 0 || bitCount != 0) && scanBusy !== 1'b1) begin
				errors++;
				$display("Error at %0d ns: scanner went idle in the middle of a scan", $time);
				seqIdx = 0;
				bitCount = 0;
			end
			if (clkOut === 1'b1) begin
				if (scanBusy !== 1'b1) begin
					errors++;
					$display("Error at %0d ns: clkOut high while the scanner is idle", $time);
				end
				if (runLen == 0) begin
					runStartIdx = seqIdx;
					if (seqIdx == XFER_IDX && !releaseSeen) begin
						errors++;
						$display("Error at %0d ns: data transfer began without ready or peer-half",
							$time);
					end
				end
				runLen++;
				shiftByte = {shiftByte[6:0], dataOut}; // MSB arrives first
				bitCount++;
				if (bitCount == 8) begin
					if (shiftByte !== expectedByte(seqIdx)) begin
						errors++;
						$display("[FAIL] %0d ns dataOut byte %0d of scan: expected 0x%02h, got 0x%02h",
							$time, seqIdx, expectedByte(seqIdx), shiftByte);
					end
					bytesSeen++;
					if (seqIdx == SEQ_LEN - 1) begin
						scansSeen++;
					end
					if (seqIdx == 1) begin
						releaseSeen = 1'b0; // Transfer must be released from here on
					end
					seqIdx = (seqIdx + 1) % SEQ_LEN;
					bitCount = 0;
				end
			end else if (runLen != 0) begin
				expLen = (runStartIdx == XFER_IDX) ? 16 : 8;
				if (runLen != expLen) begin
					errors++;
					$display("[FAIL] %0d ns clkOut run length: expected %0d, got %0d",
						$time, expLen, runLen);
				end
				runLen = 0;
				bitCount = 0; // Resync on the next frame
			end
		end
		rstPrev = rst;
		busyPrev = scanBusy;
		linkPrev = peerLink;
	end

endmodule : frameChecker

//--- design/scannerTop.sv
`timescale 1ns/1ps

module scannerTop #(
	parameter int unsigned SLOW_DIV = 16 // Clock cycles per slow tick, at least 10
) (
	input  logic                  clk,
	input  logic                  rst,
	input  frameCmdPkg::linkCode_t peerLink,
	input  logic                  readyForTransfer,
	output logic                  clkOut,
	output logic                  dataOut,
	output logic                  scanBusy
);

	import frameCmdPkg::*;

	logic       sendReq;
	frameByte_t sendCmd;
	frameByte_t sendData;
	logic       sendWithData;
	logic       busy;
	logic       done;

	scanControl #(
		.SLOW_DIV(SLOW_DIV)
	) u_scanControl (
		.clk(clk),
		.rst(rst),
		.peerLink(peerLink),
		.readyForTransfer(readyForTransfer),
		.busy(busy),
		.done(done),
		.sendReq(sendReq),
		.sendCmd(sendCmd),
		.sendData(sendData),
		.sendWithData(sendWithData),
		.scanBusy(scanBusy)
	);

	frameSerializer u_frameSerializer (
		.clk(clk),
		.rst(rst),
		.sendReq(sendReq),
		.sendCmd(sendCmd),
		.sendData(sendData),
		.sendWithData(sendWithData),
		.busy(busy),
		.done(done),
		.clkOut(clkOut),
		.dataOut(dataOut)
	);

endmodule : scannerTop

//--- design/frameSerializer.sv
`timescale 1ns/1ps

module frameSerializer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sendReq,
	input  frameCmdPkg::frameByte_t sendCmd,
	input  frameCmdPkg::frameByte_t sendData,
	input  logic                   sendWithData,
	output logic                   busy,
	output logic                   done,
	output logic                   clkOut,
	output logic                   dataOut
);

	localparam logic [4:0] BITS_CMD  = 5'd8;
	localparam logic [4:0] BITS_DATA = 5'd16;

	logic [15:0] shiftReg; // Command byte in the upper half
	logic [4:0]  bitCnt;   // Bits still to send, counting the current one

	// Control state
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			bitCnt <= '0;
		end else begin
			done <= 1'b0;
			if (sendReq && !busy) begin
				busy <= 1'b1;
				bitCnt <= sendWithData ? BITS_DATA : BITS_CMD;
			end else if (busy) begin
				bitCnt <= bitCnt - 1'b1;
				if (bitCnt == 5'd1) begin
					busy <= 1'b0; // Last bit is on the line now
					done <= 1'b1;
				end
			end
		end
	end

	// Payload shifter
	always_ff @(posedge clk) begin
		if (sendReq && !busy) begin
			shiftReg <= {sendCmd, sendWithData ? sendData : 8'h00};
		end else if (busy) begin
			shiftReg <= {shiftReg[14:0], 1'b0}; // MSB first
		end
	end

	// Strobe is high for every cycle that holds a valid bit
	assign clkOut = busy;
	assign dataOut = busy & shiftReg[15];

endmodule : frameSerializer

//--- design/scanControl.sv
`timescale 1ns/1ps

module scanControl #(
	parameter int unsigned SLOW_DIV = 16
) (
	input  logic                   clk,
	input  logic                   rst,
	input  frameCmdPkg::linkCode_t  peerLink,
	input  logic                   readyForTransfer,
	input  logic                   busy,
	input  logic                   done,
	output logic                   sendReq,
	output frameCmdPkg::frameByte_t sendCmd,
	output frameCmdPkg::frameByte_t sendData,
	output logic                   sendWithData,
	output logic                   scanBusy
);

	import scanPkg::*;
	import frameCmdPkg::*;

	localparam int unsigned TICK_W = $clog2(SLOW_DIV);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(SLOW_DIV - 1);

	logic [TICK_W-1:0] tickCnt;
	logic              tick;
	scanState_t        state;
	fillLevel_t        fill;
	fillLevel_t        fillNext;
	logic              xferSent; // Data frame already requested in this TRANSFER

	// Slow divider that paces the fill counter against the bit clock
	always_ff @(posedge clk) begin
		if (rst) begin
			tickCnt <= '0;
		end else if (tick) begin
			tickCnt <= '0;
		end else begin
			tickCnt <= tickCnt + 1'b1;
		end
	end

	assign tick = (tickCnt == TICK_LAST);
	assign fillNext = fill + 1'b1;

	// Command request decode
	// Requests go out in the same cycle as the tick so the
	// first bit lands one cycle later
	always_comb begin
		sendReq = 1'b0;
		sendCmd = CMD_READY_XFER;
		sendData = '0;
		sendWithData = 1'b0;
		case (state)
			ACTIVE: begin
				if (tick && !busy) begin
					case (fillNext)
						FILL_WARN: begin
							sendReq = 1'b1;
							sendCmd = CMD_READY_XFER;
						end
						FILL_NEAR: begin
							sendReq = 1'b1;
							sendCmd = CMD_START_SCAN;
						end
						FILL_FULL: begin
							sendReq = 1'b1;
							sendCmd = CMD_FULL;
						end
						default: begin
							sendReq = 1'b0; // Below the warning level
						end
					endcase
				end
			end
			TRANSFER: begin
				// Waits out a CMD_FULL frame still on the line
				if (!busy && !xferSent) begin
					sendReq = 1'b1;
					sendCmd = CMD_DATA_XFER;
					sendData = frameByte_t'(fill); // Zero-extended fill level
					sendWithData = 1'b1;
				end
			end
			default: begin
				sendReq = 1'b0;
			end
		endcase
	end

	// Scanner FSM and fill counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			fill <= '0;
			xferSent <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (tick && peerLink == LINK_START) begin
						state <= ACTIVE;
						fill <= '0;
					end
				end
				ACTIVE: begin
					if (tick) begin
						fill <= fillNext; // Stand-in for real scan data
						if (fillNext == FILL_FULL) begin
							state <= readyForTransfer ? TRANSFER : STANDBY;
						end
					end
				end
				STANDBY: begin
					if (tick && (readyForTransfer || peerLink == LINK_PEER_HALF)) begin
						state <= TRANSFER;
					end
				end
				TRANSFER: begin
					if (sendReq) begin
						xferSent <= 1'b1;
					end
					// Only the done of the data frame ends the transfer
					if (done && xferSent) begin
						state <= IDLE;
						fill <= '0;
						xferSent <= 1'b0;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign scanBusy = (state != IDLE);

endmodule : scanControl

//--- design/frameCmdPkg.sv
package frameCmdPkg;

	// One byte on the serial line, sent MSB first
	typedef logic [7:0] frameByte_t;

	// Command codes understood by the output driver
	localparam frameByte_t CMD_READY_XFER = 8'd2; // Sent at FILL_WARN
	localparam frameByte_t CMD_START_SCAN = 8'd3; // Sent at FILL_NEAR
	localparam frameByte_t CMD_FULL       = 8'd4; // Sent at FILL_FULL
	localparam frameByte_t CMD_DATA_XFER  = 8'd7; // Followed by a data byte

	// Two-bit peer link between the two scanner nodes
	typedef logic [1:0] linkCode_t;

	// Codes seen on the peer link
	localparam linkCode_t LINK_START     = 2'b01; // Begin a scan
	localparam linkCode_t LINK_PEER_HALF = 2'b10; // Other buffer is half full

endpackage : frameCmdPkg

//--- design/scanPkg.sv
package scanPkg;

	// Controller states
	typedef enum logic [1:0] {
		IDLE     = 2'b00, // Waiting for a start code on the peer link
		ACTIVE   = 2'b01, // Filling the scan buffer
		STANDBY  = 2'b10, // Buffer full and downstream not ready yet
		TRANSFER = 2'b11  // Sending the fill level downstream
	} scanState_t;

	// Simulated scan buffer fill count, one step per slow tick
	typedef logic [3:0] fillLevel_t;

	// Fill thresholds that trigger a command to the output driver
	localparam fillLevel_t FILL_WARN = 4'd7; // 80 percent
	localparam fillLevel_t FILL_NEAR = 4'd8; // 90 percent
	localparam fillLevel_t FILL_FULL = 4'd9; // 100 percent where the scan stops

endpackage : scanPkg
